// File: note_drop.f
note_drop_pkg.sv
beat_timer.sv
note_shift_memory.sv
note_scanner.sv
block_plotter.sv
drop_control.sv
note_drop.sv
tb_clock_gen.sv
note_drop_tb.sv

// File: Bender.yml
package:
  name: note_drop

sources:
  - note_drop_pkg.sv
  - beat_timer.sv
  - note_shift_memory.sv
  - note_scanner.sv
  - block_plotter.sv
  - drop_control.sv
  - note_drop.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - note_drop_tb.sv

// File: note_drop_tb.sv
// Note engine testbench with random stimulus, row model, pixel checker, watchdog and result
module note_drop_tb
	import note_drop_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int BEAT_PERIOD  = 600;
	localparam int CLK_PERIOD   = 8;
	localparam int NUM_STEPS    = 36; // Shift, draw and erase loops; more than NUM_ROWS
	localparam int BLOCK_PIXELS = BLOCK_SIDE * BLOCK_SIDE;
	localparam int WORST_STEP   = 2 * NUM_ROWS * NUM_LANES * BLOCK_PIXELS; // Draw plus erase
	localparam longint TIMEOUT_CYCLES = 40 * WORST_STEP * 4 + 40 * BEAT_PERIOD + 200;

	logic                 clk;
	logic                 reset;
	logic                 start;
	logic [NUM_LANES-1:0] notes_in;
	logic                 pixel_ready;
	logic [X_W-1:0]       pixel_x;
	logic [Y_W-1:0]       pixel_y;
	logic [COLOUR_W-1:0]  pixel_colour;
	logic                 pixel_valid;

	logic [NUM_LANES-1:0] model_rows [NUM_ROWS]; // Reference copy of the note memory
	int                   exp_x[$];              // Expected pixel list of one pass
	int                   exp_y[$];
	int                   error_count;
	int                   check_count;
	logic                 stall_pending;         // Last cycle had valid without ready
	logic [X_W-1:0]       sample_x;
	logic [Y_W-1:0]       sample_y;
	logic [COLOUR_W-1:0]  sample_c;

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) tb_clock_gen_i (
		.clk  (clk),
		.reset(reset)
	);

	note_drop #(.BEAT_PERIOD(BEAT_PERIOD)) note_drop_i (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.notes_in    (notes_in),
		.pixel_ready (pixel_ready),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.pixel_colour(pixel_colour),
		.pixel_valid (pixel_valid)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("ERROR %s: expected %0d, actual %0d at %0t", name, expected, actual, $time);
		end
	endtask

	// Steps one rising edge, samples the pixel port, checks stall hold and draws a new ready
	task automatic advance_clock(output logic accepted);
		@(posedge clk);
		accepted = pixel_valid && pixel_ready;
		if (stall_pending)
		begin
			check_value("stall valid", 1, pixel_valid);
			check_value("stall x", sample_x, pixel_x);
			check_value("stall y", sample_y, pixel_y);
			check_value("stall colour", sample_c, pixel_colour);
		end
		stall_pending = pixel_valid && !pixel_ready;
		sample_x      = pixel_x;
		sample_y      = pixel_y;
		sample_c      = pixel_colour;
		pixel_ready  <= ($urandom_range(0, 9) < 7); // About 70 percent
	endtask

	// Runs until one pixel is accepted and leaves it in sample_*
	task automatic wait_pixel();
		logic accepted;
		accepted = 1'b0;
		while (!accepted)
			advance_clock(accepted);
	endtask

	task automatic shift_rows(input logic [NUM_LANES-1:0] notes);
		for (int r = NUM_ROWS - 1; r > 0; r--)
			model_rows[r] = model_rows[r - 1]; // Bottom row falls off
		model_rows[0] = notes;
	endtask

	// Row then lane order with 16 pixels per set bit
	task automatic expand_blocks();
		int base_x;
		int base_y;
		exp_x.delete();
		exp_y.delete();
		for (int r = 0; r < NUM_ROWS; r++)
			for (int l = 0; l < NUM_LANES; l++)
				if (model_rows[r][l])
				begin
					base_x = l * int'(LANE_PITCH) + int'(LANE_OFFSET);
					base_y = r * int'(ROW_PITCH) + int'(ROW_OFFSET);
					for (int i = 0; i < BLOCK_PIXELS; i++)
					begin
						exp_x.push_back((base_x + i / BLOCK_SIDE) % (2 ** X_W)); // Upper index half
						exp_y.push_back((base_y + i % BLOCK_SIDE) % (2 ** Y_W)); // y wraps at 8 bits
					end
				end
	endtask

	initial
	begin
		logic                 accepted;
		logic [NUM_LANES-1:0] cur_notes; // Pattern the next shift will use
		void'($urandom(32'hcba68b08));
		error_count   = 0;
		check_count   = 0;
		stall_pending = 1'b0;
		start         = 1'b0;
		pixel_ready   = 1'b0;
		cur_notes     = $urandom_range(1, 2 ** NUM_LANES - 1);
		notes_in      = cur_notes;
		for (int r = 0; r < NUM_ROWS; r++)
			model_rows[r] = '0;
		wait (reset === 1'b0);

		repeat (100)
		begin
			advance_clock(accepted);
			check_value("idle valid", 0, pixel_valid); // Nothing before start
		end
		start <= 1'b1;
		advance_clock(accepted);
		start <= 1'b0;

		for (int s = 0; s < NUM_STEPS; s++)
		begin
			shift_rows(cur_notes);
			expand_blocks();
			foreach (exp_x[i])
			begin
				wait_pixel();
				if (i == 0)
				begin
					cur_notes = $urandom_range(1, 2 ** NUM_LANES - 1); // Shift already done
					notes_in <= cur_notes;
				end
				check_value("draw x", exp_x[i], sample_x);
				check_value("draw y", exp_y[i], sample_y);
				check_value("draw colour", NOTE_COLOUR, sample_c);
			end
			// Erase must retrace the draw pass
			foreach (exp_x[i])
			begin
				wait_pixel();
				check_value("erase x", exp_x[i], sample_x);
				check_value("erase y", exp_y[i], sample_y);
				check_value("erase colour", BACKGROUND_COLOUR, sample_c);
			end
		end

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: the pixel stream did not finish within %0d cycles, errors so far: %0d",
			TIMEOUT_CYCLES, error_count);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb_clock_gen.sv
// Testbench clock and power-on reset generator
module tb_clock_gen #(
	parameter int PERIOD       = 8,  // ns
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset high from time zero, released on a rising edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: note_drop.sv
// Top level of the falling-notes engine: timer, controller, memory, scanner and plotter
module note_drop import note_drop_pkg::*; #(
	parameter int BEAT_PERIOD = 26315790 // Clocks per beat
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  logic [NUM_LANES-1:0] notes_in,
	input  logic                 pixel_ready,
	output logic [X_W-1:0]       pixel_x,
	output logic [Y_W-1:0]       pixel_y,
	output logic [COLOUR_W-1:0]  pixel_colour,
	output logic                 pixel_valid
);

	logic                 beat;
	logic                 shift_start;
	logic                 shift_done;
	logic                 scan_start;
	logic                 scan_done;
	plot_mode_t           plot_mode;
	logic [ROW_W-1:0]     row_addr;
	logic [NUM_LANES-1:0] row_data;
	logic [X_W-1:0]       block_x;
	logic [Y_W-1:0]       block_y;
	logic                 block_valid;
	logic                 block_ready;
	logic                 plot_idle;

	beat_timer #(
		.BEAT_PERIOD(BEAT_PERIOD)
	) beat_timer_i (
		.clk  (clk),
		.reset(reset),
		.beat (beat)
	);

	drop_control drop_control_i (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.beat       (beat),
		.shift_done (shift_done),
		.scan_done  (scan_done),
		.shift_start(shift_start),
		.scan_start (scan_start),
		.plot_mode  (plot_mode)
	);

	note_shift_memory note_shift_memory_i (
		.clk        (clk),
		.reset      (reset),
		.shift_start(shift_start),
		.notes_in   (notes_in),
		.row_addr   (row_addr),
		.row_data   (row_data),
		.shift_done (shift_done)
	);

	note_scanner note_scanner_i (
		.clk        (clk),
		.reset      (reset),
		.scan_start (scan_start),
		.row_addr   (row_addr),
		.row_data   (row_data),
		.block_x    (block_x),
		.block_y    (block_y),
		.block_valid(block_valid),
		.block_ready(block_ready),
		.plot_idle  (plot_idle),
		.scan_done  (scan_done)
	);

	block_plotter block_plotter_i (
		.clk         (clk),
		.reset       (reset),
		.plot_mode   (plot_mode),
		.block_x     (block_x),
		.block_y     (block_y),
		.block_valid (block_valid),
		.block_ready (block_ready),
		.plot_idle   (plot_idle),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.pixel_colour(pixel_colour),
		.pixel_valid (pixel_valid),
		.pixel_ready (pixel_ready)
	);

endmodule

// File: drop_control.sv
// Drop controller: FSM sequencing shift, draw, beat wait and erase passes
module drop_control import note_drop_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  logic       beat,
	input  logic       shift_done,
	input  logic       scan_done,
	output logic       shift_start,
	output logic       scan_start,
	output plot_mode_t plot_mode
);

	drop_state_t state;
	drop_state_t state_next;

	// Next state
	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:      if (start) state_next = SHIFT;      // Only start pulse used
			SHIFT:     if (shift_done) state_next = DRAW;
			DRAW:      if (scan_done) state_next = WAIT_BEAT;
			WAIT_BEAT: if (beat) state_next = ERASE;       // Beats elsewhere ignored
			ERASE:     if (scan_done) state_next = SHIFT;  // Loop without start
			default:   state_next = IDLE;
		endcase
	end

	// State and entry pulses
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state       <= IDLE;
			shift_start <= 1'b0;
			scan_start  <= 1'b0;
		end
		else
		begin
			state       <= state_next;
			shift_start <= (state_next == SHIFT) && (state != SHIFT); // First SHIFT cycle
			scan_start  <= (state_next == DRAW || state_next == ERASE) && (state_next != state);
		end
	end

	// Colour select held for whole pass
	assign plot_mode = (state == ERASE) ? PLOT_ERASE : PLOT_DRAW;

	// Scanner only finishes passes it was asked for
	scan_done_state: assert property (@(posedge clk) disable iff (reset)
		scan_done |-> (state == DRAW || state == ERASE))
		else $error("scan_done outside DRAW/ERASE");

	// Memory only finishes a shift it was asked for
	shift_done_state: assert property (@(posedge clk) disable iff (reset)
		shift_done |-> (state == SHIFT))
		else $error("shift_done outside SHIFT");

endmodule

// File: block_plotter.sv
// Block plotter: expands one block origin into 16 coloured pixels under pixel back-pressure
module block_plotter import note_drop_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  plot_mode_t          plot_mode,
	input  logic [X_W-1:0]      block_x,
	input  logic [Y_W-1:0]      block_y,
	input  logic                block_valid,
	output logic                block_ready,
	output logic                plot_idle,
	output logic [X_W-1:0]      pixel_x,
	output logic [Y_W-1:0]      pixel_y,
	output logic [COLOUR_W-1:0] pixel_colour,
	output logic                pixel_valid,
	input  logic                pixel_ready
);

	localparam int OFS_W = $clog2(BLOCK_SIDE); // Bits per axis offset
	localparam int IDX_W = 2 * OFS_W;          // 16 pixels -> 4 bits

	logic             busy;    // Block latched, pixels pending
	logic [IDX_W-1:0] pix_idx; // Pixel within block
	logic [X_W-1:0]   org_x;
	logic [Y_W-1:0]   org_y;

	assign block_ready = !busy;
	assign plot_idle   = !busy;
	assign pixel_valid = busy;

	// x offset from upper half of index, y offset from lower half
	assign pixel_x = org_x + X_W'(pix_idx[IDX_W-1:OFS_W]);
	assign pixel_y = org_y + Y_W'(pix_idx[OFS_W-1:0]);

	// Control
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy    <= 1'b0;
			pix_idx <= '0;
		end
		else if (!busy)
		begin
			if (block_valid)
				busy <= 1'b1; // First pixel valid next cycle
		end
		else if (pixel_ready)
		begin
			pix_idx <= pix_idx + 1'b1; // Wraps to 0 after the last pixel
			if (pix_idx == IDX_W'(BLOCK_SIDE * BLOCK_SIDE - 1))
				busy <= 1'b0;
		end
	end

	// Block payload, captured on accept
	always_ff @(posedge clk)
	begin
		if (block_valid && !busy)
		begin
			org_x        <= block_x;
			org_y        <= block_y;
			pixel_colour <= (plot_mode == PLOT_ERASE) ? BACKGROUND_COLOUR : NOTE_COLOUR;
		end
	end

	// Stalled pixel keeps its coordinate and colour
	pixel_hold: assert property (@(posedge clk) disable iff (reset)
		pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_x)
			&& $stable(pixel_y) && $stable(pixel_colour))
		else $error("pixel changed while stalled");

endmodule

// File: note_scanner.sv
// Note scanner: row and lane walk over the note memory, block origin calculation and handshake
module note_scanner import note_drop_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 scan_start,
	output logic [ROW_W-1:0]     row_addr,
	input  logic [NUM_LANES-1:0] row_data,
	output logic [X_W-1:0]       block_x,
	output logic [Y_W-1:0]       block_y,
	output logic                 block_valid,
	input  logic                 block_ready,
	input  logic                 plot_idle,
	output logic                 scan_done
);

	typedef enum logic [2:0] {
		S_IDLE,  // Waiting for scan_start
		S_FETCH, // Row address out, data next cycle
		S_LANE,  // Test current lane bit
		S_BLOCK, // Block offered to plotter
		S_FLUSH  // Last block still being drawn
	} scan_state_t;

	scan_state_t       state;
	logic [LANE_W-1:0] lane_cnt;
	logic              lane_set;
	logic              advance;   // Done with current lane
	logic              last_lane;
	logic              last_row;

	assign lane_set  = row_data[lane_cnt]; // row_data stable while row_addr holds
	assign last_lane = (lane_cnt == LANE_W'(NUM_LANES - 1));
	assign last_row  = (row_addr == ROW_W'(NUM_ROWS - 1));
	assign advance   = ((state == S_LANE) && !lane_set) || ((state == S_BLOCK) && block_ready);

	// row_addr doubles as the row counter
	always_ff @(posedge clk)
	begin
		scan_done <= 1'b0;
		if (reset)
		begin
			state       <= S_IDLE;
			row_addr    <= '0;
			lane_cnt    <= '0;
			block_valid <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (scan_start)
					begin
						row_addr <= '0;
						lane_cnt <= '0;
						state    <= S_FETCH;
					end
				S_FETCH: state <= S_LANE; // Memory read in flight
				S_LANE:
					if (lane_set)
					begin
						block_valid <= 1'b1;
						state       <= S_BLOCK;
					end
				S_BLOCK:
					if (block_ready)
						block_valid <= 1'b0; // Accepted
				S_FLUSH:
					if (plot_idle)
					begin
						scan_done <= 1'b1; // Whole pass emitted
						state     <= S_IDLE;
					end
				default: state <= S_IDLE;
			endcase

			// Step lane, then row; overrides the case above
			if (advance)
			begin
				if (last_lane)
				begin
					lane_cnt <= '0;
					if (last_row)
						state <= S_FLUSH;
					else
					begin
						row_addr <= row_addr + 1'b1;
						state    <= S_FETCH;
					end
				end
				else
				begin
					lane_cnt <= lane_cnt + 1'b1;
					state    <= S_LANE;
				end
			end
		end
	end

	// Block origin, loaded only when a set lane is found
	// Lower rows wrap within Y_W bits
	always_ff @(posedge clk)
	begin
		if (state == S_LANE && lane_set)
		begin
			block_x <= X_W'(lane_cnt) * LANE_PITCH + LANE_OFFSET;
			block_y <= Y_W'(row_addr) * ROW_PITCH + ROW_OFFSET;
		end
	end

	// Offered block holds until the plotter takes it
	block_hold: assert property (@(posedge clk) disable iff (reset)
		block_valid && !block_ready |=> block_valid && $stable(block_x) && $stable(block_y))
		else $error("block origin changed while stalled");

endmodule

// File: note_shift_memory.sv
// Note shift memory: 32 x 5 register array with row-by-row downward shift and scan read port
module note_shift_memory import note_drop_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 shift_start,
	input  logic [NUM_LANES-1:0] notes_in,
	input  logic [ROW_W-1:0]     row_addr,
	output logic [NUM_LANES-1:0] row_data,
	output logic                 shift_done
);

	logic [NUM_LANES-1:0] mem [NUM_ROWS]; // One bit per lane per row

	logic             shifting;  // Shift in progress
	logic [ROW_W-1:0] shift_row; // Row being written this cycle

	// Shift sequencer
	// Bottom row first so each source is read before it is overwritten
	always_ff @(posedge clk)
	begin
		shift_done <= 1'b0;
		if (reset)
		begin
			shifting  <= 1'b0;
			shift_row <= '0;
			for (int r = 0; r < NUM_ROWS; r++)
			begin
				mem[r] <= '0; // Empty screen
			end
		end
		else if (shifting)
		begin
			if (shift_row == '0)
			begin
				mem[0]     <= notes_in; // New row enters at the top
				shifting   <= 1'b0;
				shift_done <= 1'b1;
			end
			else
			begin
				mem[shift_row] <= mem[shift_row - 1'b1]; // Row 31 content is lost
				shift_row      <= shift_row - 1'b1;
			end
		end
		else if (shift_start)
		begin
			shifting  <= 1'b1;
			shift_row <= ROW_W'(NUM_ROWS - 1); // Start at the bottom
		end
	end

	// Registered read, one cycle latency
	always_ff @(posedge clk)
	begin
		row_data <= mem[row_addr];
	end

endmodule

// File: beat_timer.sv
// Beat timer: free-running counter with one-cycle beat pulse per period
module beat_timer #(
	parameter int BEAT_PERIOD = 26315790
) (
	input  logic clk,
	input  logic reset,
	output logic beat
);

	// At least one bit, even for tiny periods
	localparam int CNT_W = (BEAT_PERIOD > 1) ? $clog2(BEAT_PERIOD) : 1;

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			beat  <= 1'b0;
		end
		else
		begin
			beat <= (count == CNT_W'(BEAT_PERIOD - 1)); // Pulse on wrap
			if (count == CNT_W'(BEAT_PERIOD - 1))
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	// One cycle wide, never back to back
	beat_single: assert property (@(posedge clk) disable iff (reset) beat |=> !beat)
		else $error("beat held high for two cycles");

endmodule

// File: note_drop_pkg.sv
// Shared geometry, memory size, colour constants and state/opcode enums for the note engine
package note_drop_pkg;

	// Note memory shape
	localparam int NUM_ROWS  = 32;
	localparam int NUM_LANES = 5;
	localparam int ROW_W     = 5; // Row index
	localparam int LANE_W    = 3; // Lane index

	// Screen is 320 x 240
	localparam int X_W      = 9;
	localparam int Y_W      = 8;
	localparam int COLOUR_W = 3;

	// Block origin = index * pitch + offset
	localparam logic [X_W-1:0] LANE_PITCH  = X_W'(52);
	localparam logic [X_W-1:0] LANE_OFFSET = X_W'(52);
	localparam logic [Y_W-1:0] ROW_PITCH   = Y_W'(17);
	localparam logic [Y_W-1:0] ROW_OFFSET  = Y_W'(8);

	localparam int BLOCK_SIDE = 4; // Square block, 16 pixels

	localparam logic [COLOUR_W-1:0] NOTE_COLOUR       = 3'd2; // Green
	localparam logic [COLOUR_W-1:0] BACKGROUND_COLOUR = 3'd0; // Black

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE,
		SHIFT,
		DRAW,
		WAIT_BEAT,
		ERASE
	} drop_state_t;

	// Plotter opcode, picks the colour
	typedef enum logic {
		PLOT_DRAW,
		PLOT_ERASE
	} plot_mode_t;

endpackage
